// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/decode_pkg.sv
      - hdl/alu_decode.sv
      - hdl/wb_decode.sv
      - hdl/flow_decode.sv
      - hdl/decode_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/decode_checker.sv
      - testbench/tb_decode_stage.sv

// ==== all.f ====
+incdir+include
hdl/decode_pkg.sv
hdl/alu_decode.sv
hdl/wb_decode.sv
hdl/flow_decode.sv
hdl/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode_stage.sv

// ==== hdl/alu_decode.sv ====
// ======================================================================
// alu decoder
// maps the opcode, and the function bits of the two R-type groups,
// to the alu operation, b operand source, modifiers and carry-in
// ======================================================================

`timescale 1ns/1ns

module alu_decode (
    input  decode_pkg::opcode_t   opcode,
    input  decode_pkg::func_t     func,
    output decode_pkg::alu_ctrl_t alu
);

    always_comb begin
        alu = '0;                                        // rol, b zero, no modifiers
        case (opcode) inside
            5'b01000: begin                              // addi
                alu.op    = decode_pkg::alu_add;
                alu.b_src = decode_pkg::b_src_se5;
            end
            5'b01001: begin                              // subi, imm minus rs
                alu.op    = decode_pkg::alu_add;
                alu.b_src = decode_pkg::b_src_se5;
                alu.swap  = 1'b1;
                alu.inv_b = 1'b1;
                alu.cin   = 1'b1;                        // two's complement
            end
            5'b01010: begin                              // xori
                alu.op    = decode_pkg::alu_xor;
                alu.b_src = decode_pkg::b_src_ze5;
            end
            5'b01011: begin                              // andni
                alu.op    = decode_pkg::alu_and;
                alu.b_src = decode_pkg::b_src_ze5;
                alu.inv_b = 1'b1;
            end
            5'b101??: begin                              // roli slli rori srli
                alu.op    = decode_pkg::alu_op_e'({2'b00, opcode[1:0]});
                alu.b_src = decode_pkg::b_src_ze5;
            end
            5'b10000, 5'b10001, 5'b10011: begin          // st ld stu address add
                alu.op    = decode_pkg::alu_add;
                alu.b_src = decode_pkg::b_src_se5;
                alu.sign  = 1'b1;
            end
            5'b10010: begin                              // slbi
                alu.op    = decode_pkg::alu_slbi;
                alu.b_src = decode_pkg::b_src_se8;
            end
            5'b11000: begin                              // lbi
                alu.op    = decode_pkg::alu_lbi;
                alu.b_src = decode_pkg::b_src_se8;
            end
            5'b11001: alu.op = decode_pkg::alu_btr;      // b unused
            5'b11010: begin                              // shift r-type
                alu.b_src = decode_pkg::b_src_reg;
                case (func)
                    2'b00:   alu.op = decode_pkg::alu_sll;
                    2'b01:   alu.op = decode_pkg::alu_srl;
                    2'b10:   alu.op = decode_pkg::alu_rol;
                    default: alu.op = decode_pkg::alu_ror;
                endcase
            end
            5'b11011: begin                              // arithmetic r-type
                alu.b_src = decode_pkg::b_src_reg;
                case (func)
                    2'b00: alu.op = decode_pkg::alu_add;
                    2'b01: begin                         // sub, rt minus rs
                        alu.op    = decode_pkg::alu_sub;
                        alu.swap  = 1'b1;
                        alu.inv_b = 1'b1;
                        alu.cin   = 1'b1;
                    end
                    2'b10: alu.op = decode_pkg::alu_xor;
                    default: begin                       // andn
                        alu.op    = decode_pkg::alu_and;
                        alu.inv_b = 1'b1;
                    end
                endcase
            end
            5'b11100: begin                              // seq
                alu.op    = decode_pkg::alu_seq;
                alu.b_src = decode_pkg::b_src_reg;
                alu.sign  = 1'b1;
            end
            5'b11101: begin                              // slt, compare via subtract
                alu.op    = decode_pkg::alu_slt;
                alu.b_src = decode_pkg::b_src_reg;
                alu.sign  = 1'b1;
                alu.cin   = 1'b1;
            end
            5'b11110: begin                              // sle
                alu.op    = decode_pkg::alu_sle;
                alu.b_src = decode_pkg::b_src_reg;
                alu.cin   = 1'b1;
            end
            5'b11111: begin                              // sco
                alu.op    = decode_pkg::alu_sco;
                alu.b_src = decode_pkg::b_src_reg;
                alu.sign  = 1'b1;
            end
            default: ;                                   // halt nop jumps branches
        endcase
    end

    // a swapped operand pair is only ever used for subtraction
    swap_is_sub: assert final (!alu.swap || (alu.inv_b && alu.cin))
        else $error("alu_decode: swap without inv_b and cin, opcode %b", opcode);

endmodule

// ==== hdl/decode_pkg.sv ====
// ======================================================================
// decode package
// instruction vector types, select encodings and the control word
// structs passed from the decoders to the pipeline register
// ======================================================================

`include "decode_config.svh"

package decode_pkg;

    // instruction vectors
    typedef logic [`DECODE_INSTR_W-1:0]  instr_t;    // full word
    typedef logic [`DECODE_OPCODE_W-1:0] opcode_t;   // bits 15:11
    typedef logic [`DECODE_FUNC_W-1:0]   func_t;     // bits 1:0

    // alu operation, numbering follows the alu result mux
    typedef enum logic [3:0] {
        alu_rol  = 4'd0,
        alu_sll  = 4'd1,
        alu_ror  = 4'd2,
        alu_srl  = 4'd3,
        alu_add  = 4'd4,
        alu_and  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sco  = 4'd8,     // set on carry out
        alu_slbi = 4'd9,     // shift and load byte
        alu_btr  = 4'd10,    // bit reverse
        alu_slt  = 4'd11,
        alu_lbi  = 4'd12,
        alu_sle  = 4'd13,
        alu_seq  = 4'd14,
        alu_sub  = 4'd15
    } alu_op_e;

    // alu b operand source
    typedef enum logic [2:0] {
        b_src_zero = 3'd0,   // constant 0
        b_src_reg  = 3'd1,   // second read port
        b_src_se8  = 3'd2,   // sign-extended imm8
        b_src_se5  = 3'd3,   // sign-extended imm5
        b_src_ze5  = 3'd4    // zero-extended imm5
    } b_src_e;

    // register file write data
    typedef enum logic [1:0] {
        wb_src_mem    = 2'd0,
        wb_src_alu    = 2'd1,
        wb_src_cond   = 2'd2,   // comparator flag
        wb_src_pc_inc = 2'd3    // link address
    } wb_src_e;

    // destination register field
    typedef enum logic [1:0] {
        dst_rd_hi  = 2'd0,   // instr[10:8]
        dst_rd_mid = 2'd1,   // instr[7:5]
        dst_rd_lo  = 2'd2,   // instr[4:2]
        dst_r7     = 2'd3    // link register
    } dst_sel_e;

    // branch condition on rs, same order as opcode bits 12:11
    typedef enum logic [1:0] {
        br_eqz = 2'd0,
        br_nez = 2'd1,
        br_ltz = 2'd2,
        br_gez = 2'd3
    } br_cond_e;

    typedef struct packed {
        alu_op_e op;
        b_src_e  b_src;
        logic    inv_a;
        logic    inv_b;
        logic    swap;      // exchange a and b before the adder
        logic    cin;
        logic    sign;      // signed compare and overflow
    } alu_ctrl_t;

    typedef struct packed {
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        dst_sel_e dst_sel;
        wb_src_e  wb_src;
    } mem_wb_ctrl_t;

    typedef struct packed {
        logic     halt;
        logic     br;
        br_cond_e br_cond;
        logic     jump;
        logic     jal;
        logic     jump_from_reg;   // base is rs, else pc_inc
        logic     offset_se11;     // imm11 offset, else imm8
    } flow_ctrl_t;

    typedef struct packed {
        alu_ctrl_t    alu;
        mem_wb_ctrl_t mem_wb;
        flow_ctrl_t   flow;
    } ctrl_word_t;

endpackage

// ==== hdl/decode_stage.sv ====
// ======================================================================
// instruction decode stage
// splits the instruction fields, runs the alu, write-back and flow
// decoders and registers the merged control word with a valid strobe
// ======================================================================

`timescale 1ns/1ns

`include "decode_config.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_valid,
    input  decode_pkg::instr_t     instr,
    output logic                   ctrl_valid,
    output decode_pkg::ctrl_word_t ctrl
);

    decode_pkg::opcode_t      opcode;
    decode_pkg::func_t        func;
    decode_pkg::alu_ctrl_t    alu_ctrl;      // combinational decoder outputs
    decode_pkg::mem_wb_ctrl_t mem_wb_ctrl;
    decode_pkg::flow_ctrl_t   flow_ctrl;
    decode_pkg::ctrl_word_t   ctrl_d;        // merged word ahead of the register

    assign opcode = instr[`DECODE_OPCODE_HI:`DECODE_OPCODE_LO];
    assign func   = instr[`DECODE_FUNC_HI:`DECODE_FUNC_LO];   // only r-type reads it

    alu_decode u_alu_decode (
        .opcode (opcode),
        .func   (func),
        .alu    (alu_ctrl)
    );

    wb_decode u_wb_decode (
        .opcode (opcode),
        .mem_wb (mem_wb_ctrl)
    );

    flow_decode u_flow_decode (
        .opcode (opcode),
        .flow   (flow_ctrl)
    );

    assign ctrl_d = '{alu: alu_ctrl, mem_wb: mem_wb_ctrl, flow: flow_ctrl};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_valid <= 1'b0;
            ctrl       <= '0;                // decodes as a nop
        end else begin
            ctrl_valid <= instr_valid;       // one cycle latency
            if (instr_valid) begin
                ctrl <= ctrl_d;              // hold last word across gaps
            end
        end
    end

    // every accepted word produces exactly one valid control word next cycle
    valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
        1'b1 |=> (ctrl_valid == $past(instr_valid)))
        else $error("decode_stage: ctrl_valid does not follow instr_valid");

endmodule

// ==== hdl/flow_decode.sv ====
// ======================================================================
// flow control decoder
// halt, the conditional branches and the jump family with its base
// and offset selects
// ======================================================================

`timescale 1ns/1ns

module flow_decode (
    input  decode_pkg::opcode_t    opcode,
    output decode_pkg::flow_ctrl_t flow
);

    always_comb begin
        flow = '0;                                            // fall through
        case (opcode) inside
            5'b00000: flow.halt = 1'b1;
            5'b011??: begin                                   // beqz bnez bltz bgez
                flow.br      = 1'b1;
                flow.br_cond = decode_pkg::br_cond_e'(opcode[1:0]);
            end
            5'b001??: begin                                   // j jr jal jalr
                flow.jump          = 1'b1;
                flow.jal           = opcode[1];               // link variants
                flow.jump_from_reg = opcode[0];               // jr jalr use rs
                flow.offset_se11   = ~opcode[0];              // j jal use imm11
            end
            default: ;
        endcase
    end

    // a branch and a jump can never compete for the next pc
    br_xor_jump: assert final (!(flow.br && flow.jump))
        else $error("flow_decode: br and jump both set, opcode %b", opcode);

    jal_is_jump: assert final (!flow.jal || flow.jump)
        else $error("flow_decode: jal without jump, opcode %b", opcode);

endmodule

// ==== hdl/wb_decode.sv ====
// ======================================================================
// memory and write-back decoder
// marks the load and store opcodes and picks the register write
// enable, destination field and write-back source
// ======================================================================

`timescale 1ns/1ns

module wb_decode (
    input  decode_pkg::opcode_t      opcode,
    output decode_pkg::mem_wb_ctrl_t mem_wb
);

    always_comb begin
        mem_wb = '0;                                         // no access, no write
        case (opcode) inside
            5'b010??, 5'b101??: begin                        // imm alu and shift imm
                mem_wb.reg_write = 1'b1;
                mem_wb.dst_sel   = decode_pkg::dst_rd_mid;
                mem_wb.wb_src    = decode_pkg::wb_src_alu;
            end
            5'b10000: begin                                  // st
                mem_wb.mem_read  = 1'b1;
                mem_wb.mem_write = 1'b1;
            end
            5'b10001: begin                                  // ld
                mem_wb.mem_read  = 1'b1;
                mem_wb.reg_write = 1'b1;
                mem_wb.dst_sel   = decode_pkg::dst_rd_mid;
                mem_wb.wb_src    = decode_pkg::wb_src_mem;
            end
            5'b10011: begin                                  // stu, base update to rs
                mem_wb.mem_read  = 1'b1;
                mem_wb.mem_write = 1'b1;
                mem_wb.reg_write = 1'b1;
                mem_wb.dst_sel   = decode_pkg::dst_rd_hi;
                mem_wb.wb_src    = decode_pkg::wb_src_alu;
            end
            5'b10010, 5'b11000: begin                        // slbi lbi
                mem_wb.reg_write = 1'b1;
                mem_wb.dst_sel   = decode_pkg::dst_rd_hi;
                mem_wb.wb_src    = decode_pkg::wb_src_alu;
            end
            5'b11001, 5'b11010, 5'b11011, 5'b111??: begin    // btr r-type compares
                mem_wb.reg_write = 1'b1;
                mem_wb.dst_sel   = decode_pkg::dst_rd_lo;
                mem_wb.wb_src    = decode_pkg::wb_src_alu;
            end
            5'b00110, 5'b00111: begin                        // jal jalr link
                mem_wb.reg_write = 1'b1;
                mem_wb.dst_sel   = decode_pkg::dst_r7;
                mem_wb.wb_src    = decode_pkg::wb_src_pc_inc;
            end
            default: ;                                       // halt nop branches j jr
        endcase
    end

    // the memory port reads on every store cycle
    write_needs_read: assert final (!mem_wb.mem_write || mem_wb.mem_read)
        else $error("wb_decode: mem_write without mem_read, opcode %b", opcode);

endmodule

// ==== include/decode_config.svh ====
// ======================================================================
// decode stage configuration
// instruction width and the bit positions of the opcode and function
// fields used by the decode stage and its package
// ======================================================================

`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// instruction word
`define DECODE_INSTR_W    16           // one 16-bit instruction

// opcode field, shared by every decoder
`define DECODE_OPCODE_HI  15           // top of opcode
`define DECODE_OPCODE_LO  11           // bottom of opcode
`define DECODE_OPCODE_W   5            // 32 opcodes

// function field, only meaningful for the two R-type groups
`define DECODE_FUNC_HI    1            // top of function bits
`define DECODE_FUNC_LO    0            // bottom of function bits
`define DECODE_FUNC_W     2            // four functions per group

`endif

// ==== testbench/decode_checker.sv ====
// ======================================================================
// decode stage checker
// compares the registered control word and its valid strobe with the
// expected row, one line per test, and keeps the pass and fail counts
// ======================================================================

`timescale 1ns/1ns

module decode_checker (
    input  logic                   clk,
    input  logic                   check_en,     // expected row is live
    input  int                     row_idx,
    input  logic                   exp_valid,
    input  decode_pkg::ctrl_word_t exp_ctrl,
    input  logic                   ctrl_valid,
    input  decode_pkg::ctrl_word_t ctrl,
    output int                     pass_count,
    output int                     fail_count
);

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // dut flops and expected row both change by nba, read pre-edge values
    always @(posedge clk) begin
        if (check_en) begin
            if (ctrl_valid === exp_valid && ctrl === exp_ctrl) begin
                pass_count = pass_count + 1;
                $display("PASS row %0d: ctrl_valid %0b ctrl %h",
                         row_idx, ctrl_valid, ctrl);
            end else begin
                fail_count = fail_count + 1;
                $display("FAIL at %0t: row %0d want %0b %h got %0b %h, diff alu/wb/flow %b%b%b",
                         $time, row_idx, exp_valid, exp_ctrl, ctrl_valid, ctrl,
                         ctrl.alu !== exp_ctrl.alu,       // per group mismatch flags
                         ctrl.mem_wb !== exp_ctrl.mem_wb,
                         ctrl.flow !== exp_ctrl.flow);
            end
        end
    end

endmodule

// ==== testbench/tb_decode_stage.sv ====
// ======================================================================
// decode stage testbench
// applies a table of opcodes with random operand bits, one per cycle,
// and hands the expected control word to the checker a cycle later
// ======================================================================

`timescale 1ns/1ns

`include "decode_config.svh"

module tb_decode_stage;

    localparam decode_pkg::b_src_e   b_zero = decode_pkg::b_src_zero;
    localparam decode_pkg::b_src_e   b_reg  = decode_pkg::b_src_reg;
    localparam decode_pkg::b_src_e   b_se8  = decode_pkg::b_src_se8;
    localparam decode_pkg::b_src_e   b_se5  = decode_pkg::b_src_se5;
    localparam decode_pkg::b_src_e   b_ze5  = decode_pkg::b_src_ze5;
    localparam decode_pkg::dst_sel_e d_hi   = decode_pkg::dst_rd_hi;
    localparam decode_pkg::dst_sel_e d_mid  = decode_pkg::dst_rd_mid;
    localparam decode_pkg::dst_sel_e d_lo   = decode_pkg::dst_rd_lo;

    logic                   clk;
    logic                   arst_n;
    logic                   instr_valid;
    decode_pkg::instr_t     instr;
    logic                   ctrl_valid;
    decode_pkg::ctrl_word_t ctrl;

    decode_pkg::opcode_t    tab_opc[64];     // stimulus table
    decode_pkg::func_t      tab_func[64];
    logic                   tab_valid[64];
    decode_pkg::ctrl_word_t tab_exp[64];
    int                     n_rows = 0;

    logic                   en_d, en_q;      // expected row, two stages
    logic                   exp_valid_d, exp_valid_q;
    decode_pkg::ctrl_word_t exp_ctrl_d, exp_ctrl_q;
    int                     idx_d, idx_q;
    int                     pass_count, fail_count;
    int                     cycles = 0;
    int                     cycle_limit = 1000;   // replaced once the table is built
    logic [16:0]            lfsr = 17'd70777;

    always #5 clk = ~clk;

    decode_stage u_decode_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl_valid  (ctrl_valid),
        .ctrl        (ctrl)
    );

    decode_checker u_checker (
        .clk        (clk),
        .check_en   (en_q),
        .row_idx    (idx_q),
        .exp_valid  (exp_valid_q),
        .exp_ctrl   (exp_ctrl_q),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // x^17 + x^14 + 1, one step per bit
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic store_row(input decode_pkg::opcode_t opc, input decode_pkg::func_t fn,
                             input logic valid, input decode_pkg::ctrl_word_t e);
        tab_opc[n_rows]   = opc;
        tab_func[n_rows]  = fn;
        tab_valid[n_rows] = valid;
        tab_exp[n_rows]   = e;
        n_rows            = n_rows + 1;
    endtask

    // mods is {inv_b, swap, cin, sign}, result written from alu
    task automatic add_alu_row(input decode_pkg::opcode_t opc, input decode_pkg::func_t fn,
                               input decode_pkg::alu_op_e op, input decode_pkg::b_src_e b_src,
                               input logic [3:0] mods, input decode_pkg::dst_sel_e dst);
        decode_pkg::ctrl_word_t e;
        e                  = '0;
        e.alu.op           = op;
        e.alu.b_src        = b_src;
        {e.alu.inv_b, e.alu.swap, e.alu.cin, e.alu.sign} = mods;
        e.mem_wb.reg_write = 1'b1;
        e.mem_wb.dst_sel   = dst;
        e.mem_wb.wb_src    = decode_pkg::wb_src_alu;
        store_row(opc, fn, 1'b1, e);
    endtask

    // address is always rs plus signed imm5
    task automatic add_mem_row(input decode_pkg::opcode_t opc, input logic mem_write,
                               input logic reg_write, input decode_pkg::dst_sel_e dst,
                               input decode_pkg::wb_src_e wb);
        decode_pkg::ctrl_word_t e;
        e                  = '0;
        e.alu.op           = decode_pkg::alu_add;
        e.alu.b_src        = b_se5;
        e.alu.sign         = 1'b1;
        e.mem_wb.mem_read  = 1'b1;
        e.mem_wb.mem_write = mem_write;
        e.mem_wb.reg_write = reg_write;
        e.mem_wb.dst_sel   = dst;
        e.mem_wb.wb_src    = wb;
        store_row(opc, 2'b00, 1'b1, e);
    endtask

    // bits is {halt, br, jump, jal, jump_from_reg, offset_se11}
    task automatic add_flow_row(input decode_pkg::opcode_t opc, input logic [5:0] bits,
                                input decode_pkg::br_cond_e cond);
        decode_pkg::ctrl_word_t e;
        e = '0;
        {e.flow.halt, e.flow.br, e.flow.jump, e.flow.jal,
         e.flow.jump_from_reg, e.flow.offset_se11} = bits;
        e.flow.br_cond = cond;                                    // eqz unless a branch
        if (e.flow.jal) begin                                     // link into r7
            e.mem_wb.reg_write = 1'b1;
            e.mem_wb.dst_sel   = decode_pkg::dst_r7;
            e.mem_wb.wb_src    = decode_pkg::wb_src_pc_inc;
        end
        store_row(opc, 2'b00, 1'b1, e);
    endtask

    // valid low, ctrl holds the previous word
    task automatic add_gap(input decode_pkg::opcode_t opc);
        store_row(opc, 2'b11, 1'b0, (n_rows == 0) ? '0 : tab_exp[n_rows-1]);
    endtask

    task automatic build_table();
        add_gap(5'b10011);                                           // reset value
        add_flow_row(5'b00000, 6'b100000, decode_pkg::br_eqz);       // halt
        add_flow_row(5'b00001, 6'b000000, decode_pkg::br_eqz);       // nop
        add_flow_row(5'b00010, 6'b000000, decode_pkg::br_eqz);       // siic
        add_flow_row(5'b00011, 6'b000000, decode_pkg::br_eqz);       // rti
        add_alu_row(5'b01000, 2'b00, decode_pkg::alu_add, b_se5, 4'b0000, d_mid);  // addi
        add_alu_row(5'b01001, 2'b00, decode_pkg::alu_add, b_se5, 4'b1110, d_mid);  // subi
        add_alu_row(5'b01010, 2'b00, decode_pkg::alu_xor, b_ze5, 4'b0000, d_mid);  // xori
        add_alu_row(5'b01011, 2'b00, decode_pkg::alu_and, b_ze5, 4'b1000, d_mid);  // andni
        add_gap(5'b11111);
        add_alu_row(5'b10100, 2'b00, decode_pkg::alu_rol, b_ze5, 4'b0000, d_mid);
        add_alu_row(5'b10101, 2'b00, decode_pkg::alu_sll, b_ze5, 4'b0000, d_mid);
        add_alu_row(5'b10110, 2'b00, decode_pkg::alu_ror, b_ze5, 4'b0000, d_mid);
        add_alu_row(5'b10111, 2'b00, decode_pkg::alu_srl, b_ze5, 4'b0000, d_mid);
        add_mem_row(5'b10000, 1'b1, 1'b0, d_hi, decode_pkg::wb_src_mem);           // st
        add_mem_row(5'b10001, 1'b0, 1'b1, d_mid, decode_pkg::wb_src_mem);          // ld
        add_mem_row(5'b10011, 1'b1, 1'b1, d_hi, decode_pkg::wb_src_alu);           // stu
        add_gap(5'b00110);
        add_alu_row(5'b10010, 2'b00, decode_pkg::alu_slbi, b_se8, 4'b0000, d_hi);
        add_alu_row(5'b11000, 2'b00, decode_pkg::alu_lbi, b_se8, 4'b0000, d_hi);
        add_alu_row(5'b11001, 2'b00, decode_pkg::alu_btr, b_zero, 4'b0000, d_lo);
        add_alu_row(5'b11011, 2'b00, decode_pkg::alu_add, b_reg, 4'b0000, d_lo);
        add_alu_row(5'b11011, 2'b01, decode_pkg::alu_sub, b_reg, 4'b1110, d_lo);
        add_alu_row(5'b11011, 2'b10, decode_pkg::alu_xor, b_reg, 4'b0000, d_lo);
        add_alu_row(5'b11011, 2'b11, decode_pkg::alu_and, b_reg, 4'b1000, d_lo);   // andn
        add_alu_row(5'b11010, 2'b00, decode_pkg::alu_sll, b_reg, 4'b0000, d_lo);
        add_alu_row(5'b11010, 2'b01, decode_pkg::alu_srl, b_reg, 4'b0000, d_lo);
        add_alu_row(5'b11010, 2'b10, decode_pkg::alu_rol, b_reg, 4'b0000, d_lo);
        add_alu_row(5'b11010, 2'b11, decode_pkg::alu_ror, b_reg, 4'b0000, d_lo);
        add_alu_row(5'b11100, 2'b00, decode_pkg::alu_seq, b_reg, 4'b0001, d_lo);
        add_alu_row(5'b11101, 2'b00, decode_pkg::alu_slt, b_reg, 4'b0011, d_lo);
        add_alu_row(5'b11110, 2'b00, decode_pkg::alu_sle, b_reg, 4'b0010, d_lo);
        add_alu_row(5'b11111, 2'b00, decode_pkg::alu_sco, b_reg, 4'b0001, d_lo);
        add_flow_row(5'b01100, 6'b010000, decode_pkg::br_eqz);       // beqz
        add_flow_row(5'b01101, 6'b010000, decode_pkg::br_nez);       // bnez
        add_flow_row(5'b01110, 6'b010000, decode_pkg::br_ltz);       // bltz
        add_flow_row(5'b01111, 6'b010000, decode_pkg::br_gez);       // bgez
        add_flow_row(5'b00100, 6'b001001, decode_pkg::br_eqz);       // j
        add_flow_row(5'b00101, 6'b001010, decode_pkg::br_eqz);       // jr
        add_flow_row(5'b00110, 6'b001101, decode_pkg::br_eqz);       // jal
        add_flow_row(5'b00111, 6'b001110, decode_pkg::br_eqz);       // jalr
    endtask

    always @(posedge clk) begin                  // expected row one cycle behind
        en_q        <= en_d;
        exp_valid_q <= exp_valid_d;
        exp_ctrl_q  <= exp_ctrl_d;
        idx_q       <= idx_d;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("ERROR: run hung, no end after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        decode_pkg::instr_t word;
        int                 i;
        int                 b;
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        en_d        = 1'b0;
        en_q        = 1'b0;
        exp_valid_d = 1'b0;
        exp_ctrl_d  = '0;
        idx_d       = 0;
        build_table();
        cycle_limit = n_rows + 16 + 20;          // rows, reset, margin
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (i = 0; i < n_rows; i++) begin
            @(posedge clk);
            word = '0;
            for (b = `DECODE_FUNC_HI + 1; b < `DECODE_OPCODE_LO; b++) begin
                lfsr    = lfsr_next(lfsr);       // operand bits are don't care
                word[b] = lfsr[0];
            end
            word[`DECODE_OPCODE_HI:`DECODE_OPCODE_LO] = tab_opc[i];
            word[`DECODE_FUNC_HI:`DECODE_FUNC_LO]     = tab_func[i];
            instr_valid <= tab_valid[i];
            instr       <= word;
            en_d        <= 1'b1;
            exp_valid_d <= tab_valid[i];
            exp_ctrl_d  <= tab_exp[i];
            idx_d       <= i;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        en_d        <= 1'b0;
        repeat (2) @(posedge clk);               // drain the last check
        $display("tests %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0 && pass_count == n_rows) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
